// ==== hw/bignum_pkg.sv ====
package bignum_pkg;

    // operand geometry.
    localparam int word_w    = 32;
    localparam int num_words = 8;
    localparam int idx_w     = $clog2(num_words);
    localparam int bank_w    = 2;

    typedef logic [word_w-1:0] word_t;
    typedef logic [idx_w-1:0]  idx_t;
    typedef logic [bank_w-1:0] bank_t;

    // index of the most significant word.
    localparam idx_t last_idx = idx_t'(num_words - 1);

    // bank selectors of the operand store.
    localparam bank_t bank_a = 2'd0;
    localparam bank_t bank_b = 2'd1;
    localparam bank_t bank_r = 2'd2;

endpackage

// ==== hw/cop_cmd_pkg.sv ====
package cop_cmd_pkg;

    // host commands. codes 6 and 7 are unused.
    typedef enum logic [2:0] {
        op_load_a = 3'd0,
        op_load_b = 3'd1,
        op_read_r = 3'd2,
        op_add    = 3'd3,
        op_sub    = 3'd4,
        op_cmp    = 3'd5
    } op_t;

    // magnitude verdict of a against b.
    typedef enum logic [1:0] {
        cmp_eq = 2'd0,
        cmp_gt = 2'd1,
        cmp_lt = 2'd3
    } cmp_t;

    typedef enum logic [2:0] {
        idle,
        write,
        read,
        read_out,
        sweep,
        drain,
        finish
    } seq_state_t;

endpackage

// ==== hw/operand_ram.sv ====
module operand_ram
    import bignum_pkg::*;
(
    input  logic  clk,
    input  logic  we,
    input  bank_t wbank,
    input  idx_t  widx,
    input  word_t wword,
    input  idx_t  ridx,
    input  logic  rsel_r,
    output word_t word_a,
    output word_t word_b
);

    word_t mem_a [num_words];
    word_t mem_b [num_words];
    word_t mem_r [num_words];

    always_ff @(posedge clk) begin
        if (we) begin
            case (wbank)
                bank_a:  mem_a[widx] <= wword;
                bank_b:  mem_b[widx] <= wword;
                bank_r:  mem_r[widx] <= wword;
                default: ; // bank 3 does not exist.
            endcase
        end
    end

    // both ports share one index.
    always_ff @(posedge clk) begin
        if (rsel_r) begin
            word_a <= mem_r[ridx];
        end else begin
            word_a <= mem_a[ridx];
        end
        word_b <= mem_b[ridx];
    end

endmodule

// ==== hw/word_addsub.sv ====
module word_addsub
    import bignum_pkg::*;
(
    input  logic  clk,
    input  logic  stb,
    input  logic  en,
    input  logic  first,
    input  logic  sub,
    input  word_t a,
    input  word_t b,
    output word_t sum,
    output logic  carry
);

    word_t             b_in;
    logic              cin;
    logic [word_w:0]   total;

    // subtract is a plus not b plus one.
    always_comb begin
        b_in  = sub ? ~b : b;
        cin   = first ? sub : carry;
        total = {1'b0, a} + {1'b0, b_in} + {{word_w{1'b0}}, cin};
    end

    always_ff @(posedge clk or posedge stb) begin
        if (stb) begin
            carry <= 1'b0;
        end else if (en) begin
            carry <= total[word_w]; // chained into the next word.
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            sum <= total[word_w-1:0];
        end
    end

endmodule

// ==== hw/word_compare.sv ====
module word_compare
    import bignum_pkg::*;
    import cop_cmd_pkg::*;
(
    input  logic  clk,
    input  logic  stb,
    input  logic  en,
    input  logic  first,
    input  word_t a,
    input  word_t b,
    output cmp_t  verdict
);

    cmp_t word_v;

    always_comb begin
        if (a == b) begin
            word_v = cmp_eq;
        end else if (a > b) begin
            word_v = cmp_gt;
        end else begin
            word_v = cmp_lt;
        end
    end

    // words arrive low to high, so a later difference wins.
    always_ff @(posedge clk or posedge stb) begin
        if (stb) begin
            verdict <= cmp_eq;
        end else if (en) begin
            if (first) begin
                verdict <= word_v;
            end else if (word_v != cmp_eq) begin
                verdict <= word_v;
            end
        end
    end

endmodule

// ==== hw/cop_sequencer.sv ====
module cop_sequencer
    import bignum_pkg::*;
    import cop_cmd_pkg::*;
(
    input  logic  clk,
    input  logic  stb,
    input  logic  start,
    input  op_t   op,
    input  idx_t  idx,
    input  word_t wdata,
    output logic  we,
    output bank_t wbank,
    output idx_t  widx,
    output word_t wword,
    output idx_t  ridx,
    output logic  rsel_r,
    input  word_t word_a,
    output logic  unit_en,
    output logic  unit_first,
    output logic  unit_sub,
    input  word_t sum,
    input  logic  sum_carry,
    input  cmp_t  verdict,
    output logic  busy,
    output logic  done,
    output word_t rdata,
    output cmp_t  cmp_res,
    output logic  carry
);

    seq_state_t state;
    op_t        cur_op;
    word_t      cur_data;
    logic       issue_v;
    logic       res_v;
    idx_t       idx_d1;
    idx_t       idx_d2;
    logic       load_w;

    assign load_w = (state == write);

    always_ff @(posedge clk or posedge stb) begin
        if (stb) begin
            state      <= idle;
            cur_op     <= op_load_a;
            ridx       <= '0;
            issue_v    <= 1'b0;
            unit_en    <= 1'b0;
            unit_first <= 1'b0;
            res_v      <= 1'b0;
            done       <= 1'b0;
            rdata      <= '0;
            cmp_res    <= cmp_eq;
            carry      <= 1'b0;
        end else begin
            done       <= 1'b0;
            unit_en    <= issue_v; // word arrives one cycle after its index.
            unit_first <= issue_v && (ridx == '0);
            res_v      <= unit_en;
            case (state)
                idle: begin
                    if (start) begin
                        cur_op <= op;
                        ridx   <= idx;
                        case (op)
                            op_load_a, op_load_b: begin
                                state <= write;
                            end
                            op_read_r: begin
                                state <= read;
                            end
                            op_add, op_sub, op_cmp: begin
                                ridx    <= '0;
                                issue_v <= 1'b1;
                                state   <= sweep;
                            end
                            default: begin
                                state <= finish; // unused code is just acknowledged.
                            end
                        endcase
                    end
                end
                write: begin
                    state <= finish;
                end
                read: begin
                    state <= read_out;
                end
                read_out: begin
                    rdata <= word_a;
                    state <= finish;
                end
                sweep: begin
                    if (ridx == last_idx) begin
                        issue_v <= 1'b0;
                        state   <= drain;
                    end else begin
                        ridx <= ridx + 1'b1;
                    end
                end
                drain: begin
                    // wait until the last result has been written.
                    if (!unit_en && !res_v) begin
                        state <= finish;
                    end
                end
                finish: begin
                    done  <= 1'b1;
                    state <= idle;
                    if ((cur_op == op_add) || (cur_op == op_sub)) begin
                        carry <= sum_carry;
                    end
                    if (cur_op == op_cmp) begin
                        cmp_res <= verdict;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == idle) && start) begin
            cur_data <= wdata;
        end
        idx_d1 <= ridx;   // index of the word at the units.
        idx_d2 <= idx_d1; // index of the unit result.
    end

    always_comb begin
        we     = load_w || (res_v && (cur_op != op_cmp));
        wbank  = bank_r;
        widx   = idx_d2;
        wword  = sum;
        if (load_w) begin
            wbank = (cur_op == op_load_b) ? bank_b : bank_a;
            widx  = ridx;
            wword = cur_data;
        end
    end

    assign rsel_r   = (cur_op == op_read_r);
    assign unit_sub = (cur_op == op_sub);
    assign busy     = (state != idle);

endmodule

// ==== hw/bignum_cop.sv ====
module bignum_cop
    import bignum_pkg::*;
    import cop_cmd_pkg::*;
(
    input  logic  clk,
    input  logic  stb,
    input  logic  start,
    input  op_t   op,
    input  idx_t  idx,
    input  word_t wdata,
    output logic  busy,
    output logic  done,
    output word_t rdata,
    output cmp_t  cmp_res,
    output logic  carry
);

    logic  we;
    bank_t wbank;
    idx_t  widx;
    word_t wword;
    idx_t  ridx;
    logic  rsel_r;
    word_t word_a;
    word_t word_b;
    logic  unit_en;
    logic  unit_first;
    logic  unit_sub;
    word_t sum;
    logic  sum_carry;
    cmp_t  verdict;

    operand_ram u_ram (
        .clk    (clk),
        .we     (we),
        .wbank  (wbank),
        .widx   (widx),
        .wword  (wword),
        .ridx   (ridx),
        .rsel_r (rsel_r),
        .word_a (word_a),
        .word_b (word_b)
    );

    word_addsub u_addsub (
        .clk   (clk),
        .stb   (stb),
        .en    (unit_en),
        .first (unit_first),
        .sub   (unit_sub),
        .a     (word_a),
        .b     (word_b),
        .sum   (sum),
        .carry (sum_carry)
    );

    word_compare u_compare (
        .clk     (clk),
        .stb     (stb),
        .en      (unit_en),
        .first   (unit_first),
        .a       (word_a),
        .b       (word_b),
        .verdict (verdict)
    );

    cop_sequencer u_seq (
        .clk        (clk),
        .stb        (stb),
        .start      (start),
        .op         (op),
        .idx        (idx),
        .wdata      (wdata),
        .we         (we),
        .wbank      (wbank),
        .widx       (widx),
        .wword      (wword),
        .ridx       (ridx),
        .rsel_r     (rsel_r),
        .word_a     (word_a),
        .unit_en    (unit_en),
        .unit_first (unit_first),
        .unit_sub   (unit_sub),
        .sum        (sum),
        .sum_carry  (sum_carry),
        .verdict    (verdict),
        .busy       (busy),
        .done       (done),
        .rdata      (rdata),
        .cmp_res    (cmp_res),
        .carry      (carry)
    );

endmodule

// ==== tb/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

typedef logic [num_words*word_w-1:0] big_t;

// galois step with a right shift and feedback mask.
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
        return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
endfunction

// top bit of the result is the carry out.
function automatic logic [num_words*word_w:0] ref_add(input big_t a, input big_t b);
    return {1'b0, a} + {1'b0, b};
endfunction

function automatic logic [num_words*word_w:0] ref_sub(input big_t a, input big_t b);
    big_t diff;
    diff = a - b; // wraps modulo the operand width.
    return {a >= b, diff}; // carry set when no borrow.
endfunction

function automatic cmp_t ref_cmp(input big_t a, input big_t b);
    if (a == b) begin
        return cmp_eq;
    end
    if (a > b) begin
        return cmp_gt;
    end
    return cmp_lt;
endfunction

`endif

// ==== tb/tb_bignum_cop.sv ====
module tb_bignum_cop
    import bignum_pkg::*;
    import cop_cmd_pkg::*;
();

    `include "tb_model.svh"

    localparam int chk_none   = 0;
    localparam int chk_rdata  = 1;
    localparam int chk_carry  = 2;
    localparam int chk_cmp    = 3;
    localparam int done_limit = 64;
    localparam int sweep_lat  = num_words + 4;

    logic  clk = 1'b0;
    logic  stb;
    logic  start;
    op_t   op;
    idx_t  idx;
    word_t wdata;
    logic  busy;
    logic  done;
    word_t rdata;
    cmp_t  cmp_res;
    logic  carry;

    logic [31:0] lfsr_state;
    int          cyc = 0;
    int          done_cnt = 0;
    int          err_cnt = 0;
    int          check_cnt = 0;
    int          test_err = 0;
    int          test_cnt = 0;
    int          fail_cnt = 0;
    bit          timed_out = 1'b0;
    string       test_name;
    int          exp_kind_q[$];
    word_t       exp_val_q[$];
    int          pend_kind;
    word_t       pend_val;
    big_t        a;
    big_t        b;
    big_t        tmp;
    int          t0;
    int          t1;
    int          done_before;

    bignum_cop dut (
        .clk     (clk),
        .stb     (stb),
        .start   (start),
        .op      (op),
        .idx     (idx),
        .wdata   (wdata),
        .busy    (busy),
        .done    (done),
        .rdata   (rdata),
        .cmp_res (cmp_res),
        .carry   (carry)
    );

    always #5 clk = ~clk;

    initial begin
        forever begin
            @(posedge clk);
            cyc++;
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            test_err++;
            $display("error %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    // each done pulse retires the oldest pending command.
    initial begin
        forever begin
            @(negedge clk);
            if (!stb && done) begin
                done_cnt++;
                if (exp_kind_q.size() == 0) begin
                    err_cnt++;
                    test_err++;
                    $display("done pulsed while no command was pending");
                end else begin
                    pend_kind = exp_kind_q.pop_front();
                    pend_val  = exp_val_q.pop_front();
                    case (pend_kind)
                        chk_rdata: check("rdata", rdata, pend_val);
                        chk_carry: check("carry", 32'(carry), pend_val);
                        chk_cmp:   check("cmp_res", 32'(cmp_res), pend_val);
                        default:   ;
                    endcase
                end
            end
        end
    end

    function automatic word_t rand_word();
        word_t w;
        int    k;
        w = '0;
        for (k = 0; k < word_w; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[word_w-2:0], lfsr_state[0]};
        end
        return w;
    endfunction

    function automatic big_t rand_operand();
        big_t v;
        int   i;
        for (i = 0; i < num_words; i++) begin
            v[i*word_w +: word_w] = rand_word();
        end
        return v;
    endfunction

    task automatic begin_test(input string name);
        test_name = name;
        test_err  = 0;
        test_cnt++;
    endtask

    task automatic end_test();
        @(posedge clk); // lets the last done check land first.
        if (test_err == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            fail_cnt++;
            $display("test %s: %0d errors", test_name, test_err);
        end
    endtask

    // one-cycle start pulse that returns the cycle in which the DUT sampled it.
    task automatic issue(input op_t o, input idx_t i, input word_t d, output int ts);
        ts = cyc;
        if (timed_out) return;
        @(posedge clk);
        start <= 1'b1;
        op    <= o;
        idx   <= i;
        wdata <= d;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        ts = cyc;
    endtask

    task automatic wait_done(input string what, input int ts, input int exp_lat);
        int n;
        if (timed_out) return;
        n = 0;
        while (!done && n < done_limit) begin
            @(negedge clk);
            n++;
        end
        if (!done) begin
            timed_out = 1'b1;
            err_cnt++;
            test_err++;
            $display("timeout: %s gave no done within %0d cycles", what, n);
        end else begin
            check({what, " done latency"}, cyc - ts, exp_lat);
        end
    endtask

    task automatic run_cmd(input op_t o, input idx_t i, input word_t d, input int kind,
                           input word_t val, input int exp_lat);
        int ts;
        if (timed_out) return;
        exp_kind_q.push_back(kind);
        exp_val_q.push_back(val);
        issue(o, i, d, ts);
        check("busy", 32'(busy), 32'd1);
        wait_done(o.name(), ts, exp_lat);
    endtask

    task automatic load_pair(input big_t va, input big_t vb);
        int i;
        for (i = 0; i < num_words; i++) begin
            run_cmd(op_load_a, idx_t'(i), va[i*word_w +: word_w], chk_none, '0, 2);
            run_cmd(op_load_b, idx_t'(i), vb[i*word_w +: word_w], chk_none, '0, 2);
        end
    endtask

    task automatic read_result(input big_t exp);
        int i;
        for (i = 0; i < num_words; i++) begin
            run_cmd(op_read_r, idx_t'(i), '0, chk_rdata, exp[i*word_w +: word_w], 3);
        end
    endtask

    task automatic sweep_and_read(input op_t o, input big_t va, input big_t vb);
        logic [num_words*word_w:0] res;
        if (o == op_sub) begin
            res = ref_sub(va, vb);
        end else begin
            res = ref_add(va, vb);
        end
        run_cmd(o, '0, '0, chk_carry, word_t'(res[num_words*word_w]), sweep_lat);
        read_result(res[num_words*word_w-1:0]);
    endtask

    task automatic run_compare(input big_t va, input big_t vb);
        load_pair(va, vb);
        run_cmd(op_cmp, '0, '0, chk_cmp, word_t'(ref_cmp(va, vb)), sweep_lat);
    endtask

    initial begin
        stb        = 1'b1;
        start      = 1'b0;
        op         = op_load_a;
        idx        = '0;
        wdata      = '0;
        lfsr_state = 32'h3fd542e9;
        repeat (5) @(posedge clk);
        stb <= 1'b0;
        @(negedge clk);

        begin_test("reset");
        check("busy", 32'(busy), 32'd0);
        check("done", 32'(done), 32'd0);
        check("cmp_res", 32'(cmp_res), 32'd0);
        check("carry", 32'(carry), 32'd0);
        check("rdata", rdata, 32'd0);
        end_test();

        begin_test("add");
        a = rand_operand();
        b = rand_operand();
        load_pair(a, b);
        sweep_and_read(op_add, a, b);
        end_test();

        begin_test("sub");
        a = rand_operand();
        b = rand_operand();
        if (a < b) begin
            tmp = a;
            a   = b;
            b   = tmp;
        end
        load_pair(a, b);
        sweep_and_read(op_sub, a, b);
        load_pair(b, a); // smaller minus larger wraps.
        sweep_and_read(op_sub, b, a);
        end_test();

        begin_test("cmp");
        a = rand_operand();
        b = a;
        b[word_w-1:0] = ~a[word_w-1:0];
        run_compare(a, b);
        run_compare(a, a);
        b = a;
        a[num_words*word_w-1] = 1'b1; // top word of a larger.
        b[num_words*word_w-1] = 1'b0;
        a[word_w-1] = 1'b0; // lowest word of a smaller.
        b[word_w-1] = 1'b1;
        run_compare(a, b);
        run_compare(b, a);
        end_test();

        begin_test("start while busy");
        a = rand_operand();
        b = rand_operand();
        load_pair(a, b);
        done_before = done_cnt;
        exp_kind_q.push_back(chk_carry);
        exp_val_q.push_back(word_t'(ref_add(a, b) >> (num_words * word_w)));
        issue(op_add, '0, '0, t0);
        issue(op_load_a, '0, ~a[word_w-1:0], t1);
        wait_done("op_add", t0, sweep_lat);
        repeat (sweep_lat) @(negedge clk);
        check("done pulses", done_cnt - done_before, 32'd1);
        sweep_and_read(op_add, a, b); // a changed A would show up here.
        end_test();

        if (exp_kind_q.size() != 0) begin
            err_cnt++;
            $display("%0d commands never answered with done", exp_kind_q.size());
        end
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_cnt, fail_cnt, check_cnt, err_cnt);
        if (err_cnt == 0 && !timed_out) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+tb
hw/bignum_pkg.sv
hw/cop_cmd_pkg.sv
hw/operand_ram.sv
hw/word_addsub.sv
hw/word_compare.sv
hw/cop_sequencer.sv
hw/bignum_cop.sv
tb/tb_bignum_cop.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_bignum_cop
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(BUILD_DIR)
